// ==== hw/bp_pkg.sv ====
`default_nettype none

package bp_pkg;

    localparam int VADDR_W     = 32;
    localparam int BLOCK_BYTES = 32;
    localparam int INSN_BYTES  = 4;

    localparam logic [VADDR_W-1:0] RESET_PC = 32'h8000_0000;

    // table sizes
    localparam int UBTB_ENTRIES = 16;
    localparam int BTB_ENTRIES  = 64;
    localparam int DIR_ENTRIES  = 256;
    localparam int RAS_DEPTH    = 8;

    // byte position of a branch inside its block
    localparam int OFFSET_W = $clog2(BLOCK_BYTES);

    localparam int UBTB_IDX_W = $clog2(UBTB_ENTRIES);
    localparam int BTB_IDX_W  = $clog2(BTB_ENTRIES);
    localparam int DIR_IDX_W  = $clog2(DIR_ENTRIES);
    localparam int RAS_PTR_W  = $clog2(RAS_DEPTH);

    // everything above index and block offset goes into the tag
    localparam int UBTB_TAG_W = VADDR_W - OFFSET_W - UBTB_IDX_W;
    localparam int BTB_TAG_W  = VADDR_W - OFFSET_W - BTB_IDX_W;

    typedef enum logic [1:0] {
        COND,
        JUMP,
        CALL,
        RET
    } br_type_e;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [OFFSET_W-1:0]  offset;
        br_type_e             br_type;
        logic [VADDR_W-1:0]   target;
    } btb_entry_t;

    // one entry for the fetch target queue
    typedef struct packed {
        logic [VADDR_W-1:0]  start;
        logic [VADDR_W-1:0]  target;
        logic                taken;
        logic [OFFSET_W-1:0] offset;
        br_type_e            br_type;
        logic                redirect;
    } bp_pred_t;

    // resolved branch sent back by the queue
    typedef struct packed {
        logic [VADDR_W-1:0]  start;
        logic [OFFSET_W-1:0] offset;
        br_type_e            br_type;
        logic [VADDR_W-1:0]  target;
        logic                taken;
    } bp_update_t;

endpackage

`default_nettype wire

// ==== hw/micro_btb.sv ====
`default_nettype none

module micro_btb import bp_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire  [VADDR_W-1:0]      pc_i,
    output logic                    hit_o,
    output logic [VADDR_W-1:0]      target_o,
    output logic [OFFSET_W-1:0]     offset_o,
    output br_type_e                type_o,
    input  wire                     upd_valid_i,
    input  wire  bp_update_t        upd_i
);

    logic [UBTB_ENTRIES-1:0] valid_q;
    logic [UBTB_TAG_W-1:0]   tag_mem    [UBTB_ENTRIES];
    logic [OFFSET_W-1:0]     offset_mem [UBTB_ENTRIES];
    br_type_e                type_mem   [UBTB_ENTRIES];
    logic [VADDR_W-1:0]      target_mem [UBTB_ENTRIES];

    logic [UBTB_IDX_W-1:0]   rd_idx;
    logic [UBTB_TAG_W-1:0]   rd_tag;
    logic [UBTB_IDX_W-1:0]   wr_idx;
    logic [UBTB_TAG_W-1:0]   wr_tag;
    logic                    wr_en;

    assign rd_idx = pc_i[OFFSET_W +: UBTB_IDX_W];
    assign rd_tag = pc_i[VADDR_W-1 -: UBTB_TAG_W];
    assign wr_idx = upd_i.start[OFFSET_W +: UBTB_IDX_W];
    assign wr_tag = upd_i.start[VADDR_W-1 -: UBTB_TAG_W];

    // only unconditional direct branches, s2 covers the rest
    assign wr_en = upd_valid_i && (upd_i.br_type == JUMP || upd_i.br_type == CALL);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_idx]    <= wr_tag;
            offset_mem[wr_idx] <= upd_i.offset;
            type_mem[wr_idx]   <= upd_i.br_type;
            target_mem[wr_idx] <= upd_i.target;
        end
    end

    // same-cycle lookup
    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
    assign target_o = target_mem[rd_idx];
    assign offset_o = offset_mem[rd_idx];
    assign type_o   = type_mem[rd_idx];

endmodule

`default_nettype wire

// ==== hw/btb.sv ====
`default_nettype none

module btb import bp_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire  [VADDR_W-1:0]  pc_i,
    input  wire                 hold_i,
    output btb_entry_t          entry_o,
    input  wire                 upd_valid_i,
    input  wire  bp_update_t    upd_i
);

    logic [BTB_ENTRIES-1:0] valid_q;
    btb_entry_t             entry_mem [BTB_ENTRIES];

    logic [BTB_IDX_W-1:0]   rd_idx_q;
    logic [BTB_IDX_W-1:0]   wr_idx;
    logic [BTB_TAG_W-1:0]   wr_tag;
    btb_entry_t             wr_entry;

    assign wr_idx = upd_i.start[OFFSET_W +: BTB_IDX_W];
    assign wr_tag = upd_i.start[VADDR_W-1 -: BTB_TAG_W];

    always_comb begin
        wr_entry.valid   = 1'b1;
        wr_entry.tag     = wr_tag;
        wr_entry.offset  = upd_i.offset;
        wr_entry.br_type = upd_i.br_type;
        wr_entry.target  = upd_i.target;
    end

    // read index follows pc unless the pipe is stalled
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_idx_q <= '0;
        end else if (!hold_i) begin
            rd_idx_q <= pc_i[OFFSET_W +: BTB_IDX_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (upd_valid_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // every branch kind is kept here
    always_ff @(posedge clk) begin
        if (upd_valid_i) begin
            entry_mem[wr_idx] <= wr_entry;
        end
    end

    // raw entry, tag checked in s2
    always_comb begin
        entry_o       = entry_mem[rd_idx_q];
        entry_o.valid = valid_q[rd_idx_q];
    end

endmodule

`default_nettype wire

// ==== hw/bimodal_dir.sv ====
`default_nettype none

module bimodal_dir import bp_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire  [VADDR_W-1:0]  pc_i,
    input  wire                 hold_i,
    output logic                taken_o,
    input  wire                 upd_valid_i,
    input  wire  bp_update_t    upd_i
);

    logic [1:0]           ctr_q [DIR_ENTRIES];
    logic [DIR_IDX_W-1:0] rd_idx_q;
    logic [DIR_IDX_W-1:0] wr_idx;
    logic                 train;

    assign wr_idx = upd_i.start[OFFSET_W +: DIR_IDX_W];
    assign train  = upd_valid_i && (upd_i.br_type == COND);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_idx_q <= '0;
            // weakly not taken
            for (int i = 0; i < DIR_ENTRIES; i++) begin
                ctr_q[i] <= 2'd1;
            end
        end else begin
            if (!hold_i) begin
                rd_idx_q <= pc_i[OFFSET_W +: DIR_IDX_W];
            end
            if (train) begin
                if (upd_i.taken && ctr_q[wr_idx] != 2'd3) begin
                    ctr_q[wr_idx] <= ctr_q[wr_idx] + 2'd1;
                end else if (!upd_i.taken && ctr_q[wr_idx] != 2'd0) begin
                    ctr_q[wr_idx] <= ctr_q[wr_idx] - 2'd1;
                end
            end
        end
    end

    // msb set means 2 or 3
    assign taken_o = ctr_q[rd_idx_q][1];

endmodule

`default_nettype wire

// ==== hw/return_stack.sv ====
`default_nettype none

module return_stack import bp_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 push_i,
    input  wire  [VADDR_W-1:0]  push_addr_i,
    input  wire                 pop_i,
    output logic [VADDR_W-1:0]  top_o
);

    logic [VADDR_W-1:0]   stack_mem [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] ptr_q;
    logic [RAS_PTR_W-1:0] push_ptr;
    logic [RAS_PTR_W-1:0] pop_ptr;

    // pointer wraps, oldest entries get overwritten
    assign push_ptr = ptr_q + RAS_PTR_W'(1);
    assign pop_ptr  = ptr_q - RAS_PTR_W'(1);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ptr_q <= '0;
        end else if (push_i) begin
            ptr_q <= push_ptr;
        end else if (pop_i) begin
            ptr_q <= pop_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack_mem[push_ptr] <= push_addr_i;
        end
    end

    assign top_o = stack_mem[ptr_q];

endmodule

`default_nettype wire

// ==== hw/s2_override.sv ====
`default_nettype none

module s2_override import bp_pkg::*; (
    input  wire  bp_pred_t      s1_pred_i,
    input  wire  btb_entry_t    entry_i,
    input  wire                 dir_taken_i,
    input  wire  [VADDR_W-1:0]  ras_top_i,
    output bp_pred_t            pred_o,
    output logic                redirect_o
);

    logic [VADDR_W-1:0]   fall_through;
    logic [BTB_TAG_W-1:0] lookup_tag;
    logic                 hit;
    logic                 taken;
    logic [VADDR_W-1:0]   target;

    assign fall_through = s1_pred_i.start + VADDR_W'(BLOCK_BYTES);
    assign lookup_tag   = s1_pred_i.start[VADDR_W-1 -: BTB_TAG_W];
    assign hit          = entry_i.valid && (entry_i.tag == lookup_tag);

    always_comb begin
        taken  = 1'b0;
        target = fall_through;
        if (hit) begin
            case (entry_i.br_type)
                COND: begin
                    taken  = dir_taken_i;
                    target = dir_taken_i ? entry_i.target : fall_through;
                end
                JUMP, CALL: begin
                    taken  = 1'b1;
                    target = entry_i.target;
                end
                RET: begin
                    taken  = 1'b1;
                    target = ras_top_i;
                end
            endcase
        end
    end

    // s2 wins whenever it lands somewhere else
    assign redirect_o = (target != s1_pred_i.target);

    always_comb begin
        pred_o.start    = s1_pred_i.start;
        pred_o.target   = target;
        pred_o.taken    = taken;
        pred_o.offset   = hit ? entry_i.offset : '1;
        pred_o.br_type  = hit ? entry_i.br_type : COND;
        pred_o.redirect = redirect_o;
    end

endmodule

`default_nettype wire

// ==== hw/branch_predictor.sv ====
`default_nettype none

module branch_predictor import bp_pkg::*; (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 squash_valid_i,
    input  wire  [VADDR_W-1:0]  squash_target_i,
    input  wire                 upd_valid_i,
    input  wire  bp_update_t    upd_i,
    input  wire                 pred_ready_i,
    output logic                pred_valid_o,
    output bp_pred_t            pred_o
);

    logic [VADDR_W-1:0]  pc_q;
    logic                s2_valid_q;
    bp_pred_t            s2_in_q;

    logic                ubtb_hit;
    logic [VADDR_W-1:0]  ubtb_target;
    logic [OFFSET_W-1:0] ubtb_offset;
    br_type_e            ubtb_type;
    bp_pred_t            s1_pred;

    btb_entry_t          btb_entry;
    logic                dir_taken;
    logic [VADDR_W-1:0]  ras_top;
    bp_pred_t            s2_pred;
    logic                s2_mismatch;
    logic                s2_redirect;

    logic                fire;
    logic                s2_resolve;
    logic                ras_push;
    logic                ras_pop;
    logic [VADDR_W-1:0]  ras_push_addr;

    micro_btb u_micro_btb (
        .clk         (clk),
        .rst_i       (rst_i),
        .pc_i        (pc_q),
        .hit_o       (ubtb_hit),
        .target_o    (ubtb_target),
        .offset_o    (ubtb_offset),
        .type_o      (ubtb_type),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i)
    );

    // s1 answer, fall through on a miss
    always_comb begin
        s1_pred.start    = pc_q;
        s1_pred.target   = ubtb_hit ? ubtb_target : pc_q + VADDR_W'(BLOCK_BYTES);
        s1_pred.taken    = ubtb_hit;
        s1_pred.offset   = ubtb_hit ? ubtb_offset : '1;
        s1_pred.br_type  = ubtb_hit ? ubtb_type : COND;
        s1_pred.redirect = 1'b0;
    end

    // tables hold their read index while nothing is accepted
    btb u_btb (
        .clk         (clk),
        .rst_i       (rst_i),
        .pc_i        (pc_q),
        .hold_i      (!fire),
        .entry_o     (btb_entry),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i)
    );

    bimodal_dir u_bimodal_dir (
        .clk         (clk),
        .rst_i       (rst_i),
        .pc_i        (pc_q),
        .hold_i      (!fire),
        .taken_o     (dir_taken),
        .upd_valid_i (upd_valid_i),
        .upd_i       (upd_i)
    );

    return_stack u_return_stack (
        .clk         (clk),
        .rst_i       (rst_i),
        .push_i      (ras_push),
        .push_addr_i (ras_push_addr),
        .pop_i       (ras_pop),
        .top_o       (ras_top)
    );

    s2_override u_s2_override (
        .s1_pred_i   (s2_in_q),
        .entry_i     (btb_entry),
        .dir_taken_i (dir_taken),
        .ras_top_i   (ras_top),
        .pred_o      (s2_pred),
        .redirect_o  (s2_mismatch)
    );

    assign s2_redirect  = s2_valid_q && s2_mismatch;
    assign pred_valid_o = !squash_valid_i;
    assign fire         = pred_valid_o && pred_ready_i;
    assign pred_o       = s2_redirect ? s2_pred : s1_pred;

    // the s2 block resolves on the transfer that retires it from the s2 register
    assign s2_resolve    = fire && s2_valid_q && s2_pred.taken;
    assign ras_push      = s2_resolve && (s2_pred.br_type == CALL);
    assign ras_pop       = s2_resolve && (s2_pred.br_type == RET);
    assign ras_push_addr = s2_pred.start + VADDR_W'(s2_pred.offset) + VADDR_W'(INSN_BYTES);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q       <= RESET_PC;
            s2_valid_q <= 1'b0;
        end else if (squash_valid_i) begin
            pc_q       <= squash_target_i;
            s2_valid_q <= 1'b0;
        end else if (fire) begin
            if (s2_redirect) begin
                pc_q       <= s2_pred.target;
                s2_valid_q <= 1'b0;
            end else begin
                pc_q       <= s1_pred.target;
                s2_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && !s2_redirect) begin
            s2_in_q <= s1_pred;
        end
    end

endmodule

`default_nettype wire

// ==== test/tb_branch_predictor.sv ====
`default_nettype none

module tb_branch_predictor import bp_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic                 clk = 1'b0;
    logic                 rst_i;
    logic                 squash_valid_i;
    logic [VADDR_W-1:0]   squash_target_i;
    logic                 upd_valid_i;
    bp_update_t           upd_i;
    logic                 pred_ready_i;
    logic                 pred_valid_o;
    bp_pred_t             pred_o;

    integer               seed = 13284;
    int                   errors = 0;
    int                   checks = 0;
    int                   tests = 0;
    bit                   timed_out = 1'b0;

    // reference model state
    logic [VADDR_W-1:0]   m_pc;
    logic                 m_s2_valid;
    logic [VADDR_W-1:0]   m_s2_start;
    logic [VADDR_W-1:0]   m_s2_target;
    logic                 u_val   [UBTB_ENTRIES];
    logic [VADDR_W-1:0]   u_start [UBTB_ENTRIES];
    logic [VADDR_W-1:0]   u_tgt   [UBTB_ENTRIES];
    logic [OFFSET_W-1:0]  u_off   [UBTB_ENTRIES];
    br_type_e             u_type  [UBTB_ENTRIES];
    logic                 b_val   [BTB_ENTRIES];
    logic [VADDR_W-1:0]   b_start [BTB_ENTRIES];
    logic [VADDR_W-1:0]   b_tgt   [BTB_ENTRIES];
    logic [OFFSET_W-1:0]  b_off   [BTB_ENTRIES];
    br_type_e             b_type  [BTB_ENTRIES];
    logic [1:0]           ctr     [DIR_ENTRIES];
    logic [VADDR_W-1:0]   ras     [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] ras_ptr;

    // expected next accepted prediction
    logic [VADDR_W-1:0]   exp_start;
    logic [VADDR_W-1:0]   exp_target;
    logic                 exp_taken;
    logic                 exp_redirect;
    logic [OFFSET_W-1:0]  exp_offset;
    br_type_e             exp_kind;
    logic                 s2_taken;
    br_type_e             s2_kind;
    logic [VADDR_W-1:0]   s2_target;
    logic [VADDR_W-1:0]   s2_ret_addr;

    always #10 clk = ~clk;

    branch_predictor dut_i (
        .clk             (clk),
        .rst_i           (rst_i),
        .squash_valid_i  (squash_valid_i),
        .squash_target_i (squash_target_i),
        .upd_valid_i     (upd_valid_i),
        .upd_i           (upd_i),
        .pred_ready_i    (pred_ready_i),
        .pred_valid_o    (pred_valid_o),
        .pred_o          (pred_o)
    );

    function automatic logic same_block(input logic [VADDR_W-1:0] a,
                                        input logic [VADDR_W-1:0] b);
        return a[VADDR_W-1:OFFSET_W] == b[VADDR_W-1:OFFSET_W];
    endfunction

    function automatic void reset_model();
        m_pc       = RESET_PC;
        m_s2_valid = 1'b0;
        ras_ptr    = '0;
        for (int i = 0; i < UBTB_ENTRIES; i++) u_val[i] = 1'b0;
        for (int i = 0; i < BTB_ENTRIES; i++) b_val[i] = 1'b0;
        for (int i = 0; i < DIR_ENTRIES; i++) ctr[i] = 2'd1;
    endfunction

    function automatic void learn(input bp_update_t u);
        logic [UBTB_IDX_W-1:0] ui;
        logic [BTB_IDX_W-1:0]  bi;
        logic [DIR_IDX_W-1:0]  di;
        ui = u.start[OFFSET_W +: UBTB_IDX_W];
        bi = u.start[OFFSET_W +: BTB_IDX_W];
        di = u.start[OFFSET_W +: DIR_IDX_W];
        // micro-BTB keeps direct unconditional branches only
        if (u.br_type == JUMP || u.br_type == CALL) begin
            u_val[ui]   = 1'b1;
            u_start[ui] = u.start;
            u_tgt[ui]   = u.target;
            u_off[ui]   = u.offset;
            u_type[ui]  = u.br_type;
        end
        b_val[bi]   = 1'b1;
        b_start[bi] = u.start;
        b_tgt[bi]   = u.target;
        b_off[bi]   = u.offset;
        b_type[bi]  = u.br_type;
        if (u.br_type == COND) begin
            if (u.taken && ctr[di] != 2'd3) ctr[di] = ctr[di] + 2'd1;
            else if (!u.taken && ctr[di] != 2'd0) ctr[di] = ctr[di] - 2'd1;
        end
    endfunction

    function automatic void compute_expect();
        logic [BTB_IDX_W-1:0]  bi;
        logic [DIR_IDX_W-1:0]  di;
        logic [UBTB_IDX_W-1:0] ui;
        logic                  hit;
        logic                  u_hit;
        bi = m_s2_start[OFFSET_W +: BTB_IDX_W];
        di = m_s2_start[OFFSET_W +: DIR_IDX_W];
        ui = m_pc[OFFSET_W +: UBTB_IDX_W];
        hit = m_s2_valid && b_val[bi] && same_block(b_start[bi], m_s2_start);
        s2_taken    = 1'b0;
        s2_kind     = COND;
        s2_target   = m_s2_start + VADDR_W'(BLOCK_BYTES);
        s2_ret_addr = m_s2_start + VADDR_W'(b_off[bi]) + VADDR_W'(INSN_BYTES);
        if (hit) begin
            s2_kind = b_type[bi];
            case (b_type[bi])
                COND: begin
                    if (ctr[di] >= 2'd2) begin
                        s2_taken  = 1'b1;
                        s2_target = b_tgt[bi];
                    end
                end
                RET: begin
                    s2_taken  = 1'b1;
                    s2_target = ras[ras_ptr];
                end
                default: begin
                    s2_taken  = 1'b1;
                    s2_target = b_tgt[bi];
                end
            endcase
        end
        u_hit = u_val[ui] && same_block(u_start[ui], m_pc);
        if (m_s2_valid && s2_target != m_s2_target) begin
            exp_start    = m_s2_start;
            exp_target   = s2_target;
            exp_taken    = s2_taken;
            exp_redirect = 1'b1;
            exp_offset   = b_off[bi];
            exp_kind     = s2_kind;
        end else begin
            exp_start    = m_pc;
            exp_target   = u_hit ? u_tgt[ui] : m_pc + VADDR_W'(BLOCK_BYTES);
            exp_taken    = u_hit;
            exp_redirect = 1'b0;
            exp_offset   = u_off[ui];
            exp_kind     = u_type[ui];
        end
    endfunction

    always @(posedge clk) begin
        if (rst_i) begin
            reset_model();
        end else begin
            if (squash_valid_i) begin
                m_pc       = squash_target_i;
                m_s2_valid = 1'b0;
            end else if (pred_ready_i) begin
                // the s2 block retires on this transfer
                if (m_s2_valid && s2_taken && s2_kind == CALL) begin
                    ras_ptr      = ras_ptr + RAS_PTR_W'(1);
                    ras[ras_ptr] = s2_ret_addr;
                end else if (m_s2_valid && s2_taken && s2_kind == RET) begin
                    ras_ptr = ras_ptr - RAS_PTR_W'(1);
                end
                m_s2_valid  = !exp_redirect;
                m_s2_start  = exp_start;
                m_s2_target = exp_target;
                m_pc        = exp_target;
            end
            if (upd_valid_i) learn(upd_i);
        end
        compute_expect();
    end

    // branch position and kind only mean something for a taken block
    assert property (@(posedge clk) disable iff (rst_i)
        (pred_valid_o && pred_ready_i) |-> (pred_o.start == exp_start
            && pred_o.target == exp_target && pred_o.taken == exp_taken
            && pred_o.redirect == exp_redirect
            && (!exp_taken || (pred_o.offset == exp_offset
                               && pred_o.br_type == exp_kind))))
    else begin
        $display("Error at %0t: block %h to %h, model expects block %h to %h", $time,
                 $sampled(pred_o.start), $sampled(pred_o.target),
                 $sampled(exp_start), $sampled(exp_target));
        errors++;
    end

    assert property (@(posedge clk) disable iff (rst_i) pred_valid_o == !squash_valid_i)
    else begin
        $display("Error at %0t: pred_valid_o is %b next to a squash of %b", $time,
                 $sampled(pred_valid_o), $sampled(squash_valid_i));
        errors++;
    end

    // a stalled prediction must not move
    assert property (@(posedge clk) disable iff (rst_i)
        (pred_valid_o && !pred_ready_i && !upd_valid_i) |=>
            (!pred_valid_o || $stable(pred_o)))
    else begin
        $display("Error at %0t: pred_o changed while the queue stalled", $time);
        errors++;
    end

    task automatic check_that(input logic cond, input string what);
        if (!timed_out) begin
            checks++;
            assert (cond) else begin
                $display("Error at %0t: %s", $time, what);
                errors++;
            end
        end
    endtask

    task automatic end_run();
        $display("%0d tests, %0d directed checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    task automatic take_pred(input bit random_ready, output bp_pred_t p);
        int  n;
        bit  got;
        n   = 0;
        got = 1'b0;
        while (!got && !timed_out && n < 50) begin
            @(negedge clk);
            pred_ready_i = random_ready ? ($random(seed) % 2 == 0) : 1'b1;
            #1;
            got = pred_valid_o && pred_ready_i;
            p   = pred_o;
            n++;
        end
        if (!got && !timed_out) begin
            $display("no prediction was accepted within 50 cycles");
            timed_out = 1'b1;
        end
    endtask

    task automatic squash_to(input logic [VADDR_W-1:0] target);
        @(negedge clk);
        pred_ready_i    = 1'b0;
        squash_valid_i  = 1'b1;
        squash_target_i = target;
        @(negedge clk);
        squash_valid_i  = 1'b0;
    endtask

    task automatic train(input logic [VADDR_W-1:0] start, input logic [OFFSET_W-1:0] offset,
                         input br_type_e kind, input logic [VADDR_W-1:0] target,
                         input logic taken);
        @(negedge clk);
        pred_ready_i  = 1'b0;
        upd_valid_i   = 1'b1;
        upd_i.start   = start;
        upd_i.offset  = offset;
        upd_i.br_type = kind;
        upd_i.target  = target;
        upd_i.taken   = taken;
        @(negedge clk);
        upd_valid_i   = 1'b0;
    endtask

    task automatic test_done(input string name, input int mark);
        tests++;
        if (errors == mark) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, errors - mark);
    endtask

    initial begin
        bp_pred_t           p;
        bp_pred_t           prev;
        int                 mark;
        logic [VADDR_W-1:0] blk_a;
        logic [VADDR_W-1:0] blk_b;
        logic [VADDR_W-1:0] blk_c;
        logic [VADDR_W-1:0] blk_t;
        logic [VADDR_W-1:0] blk_d;
        logic [VADDR_W-1:0] blk_e;
        // blocks picked so that no two learned branches share a table slot
        blk_a = 32'h8000_2040;
        blk_b = 32'h8000_3000;
        blk_c = 32'h8000_4080;
        blk_t = 32'h8000_5000;
        blk_d = 32'h8000_6100;
        blk_e = 32'h8000_7200;
        rst_i           = 1'b1;
        squash_valid_i  = 1'b0;
        squash_target_i = '0;
        upd_valid_i     = 1'b0;
        upd_i           = '0;
        pred_ready_i    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        mark = errors;
        for (int i = 0; i < 8; i++) begin
            take_pred(1'b1, p);
            check_that(p.start == RESET_PC + VADDR_W'(i * BLOCK_BYTES) && !p.taken
                       && !p.redirect, "block after reset is not sequential");
        end
        test_done("reset stream", mark);

        mark = errors;
        squash_to(32'h8000_1000);
        take_pred(1'b1, p);
        check_that(p.start == 32'h8000_1000, "first block after a squash is not the target");
        take_pred(1'b1, p);
        check_that(p.start == 32'h8000_1020, "block after the squash target is wrong");
        test_done("squash", mark);

        mark = errors;
        train(blk_a, 5'd8, JUMP, blk_b, 1'b1);
        squash_to(blk_a);
        take_pred(1'b0, p);
        check_that(p.start == blk_a && p.target == blk_b && p.taken && !p.redirect,
                   "jump in A not predicted by the micro-BTB");
        take_pred(1'b0, p);
        check_that(p.start == blk_b && !p.redirect, "block after the jump is not B");
        test_done("jump", mark);

        mark = errors;
        // not taken first, so one taken update leaves the counter below 2
        train(blk_c, 5'd12, COND, blk_t, 1'b0);
        train(blk_c, 5'd12, COND, blk_t, 1'b1);
        squash_to(blk_c);
        take_pred(1'b0, p);
        check_that(p.start == blk_c && !p.taken && !p.redirect, "weak branch in C taken in s1");
        take_pred(1'b0, p);
        check_that(p.start == blk_c + 32'd32 && !p.redirect, "weak branch in C redirected");
        train(blk_c, 5'd12, COND, blk_t, 1'b1);
        squash_to(blk_c);
        take_pred(1'b0, p);
        check_that(p.start == blk_c && !p.redirect, "C not predicted by s1 first");
        take_pred(1'b0, p);
        check_that(p.start == blk_c && p.target == blk_t && p.taken && p.redirect,
                   "trained branch in C not redirected by s2");
        take_pred(1'b0, p);
        check_that(p.start == blk_t, "block after the redirect is not the branch target");
        test_done("conditional", mark);

        mark = errors;
        train(blk_d, 5'd16, CALL, blk_e, 1'b1);
        train(blk_e, 5'd4, RET, 32'h0, 1'b1);
        squash_to(blk_d);
        take_pred(1'b0, p);
        check_that(p.start == blk_d && p.target == blk_e && p.taken, "call in D not predicted");
        take_pred(1'b0, p);
        check_that(p.start == blk_e && !p.redirect, "block after the call is not E");
        take_pred(1'b0, p);
        check_that(p.start == blk_e && p.target == blk_d + 32'd20 && p.redirect,
                   "return in E not sent to the return address");
        test_done("call return", mark);

        mark = errors;
        squash_to(32'h8001_0000);
        take_pred(1'b1, prev);
        for (int i = 0; i < 24; i++) begin
            take_pred(1'b1, p);
            check_that(p.start == prev.start + 32'd32 && !p.redirect,
                       "block skipped or repeated under back-pressure");
            prev = p;
        end
        test_done("back-pressure", mark);

        end_run();
    end

endmodule

`default_nettype wire

// ==== branch_predictor.f ====
hw/bp_pkg.sv
hw/micro_btb.sv
hw/btb.sv
hw/bimodal_dir.sv
hw/return_stack.sv
hw/s2_override.sv
hw/branch_predictor.sv
test/tb_branch_predictor.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_branch_predictor -f branch_predictor.f
	out=$$(./obj_dir/Vtb_branch_predictor); echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
